// ==== source/csi_pkg.sv ====
package csi_pkg;

	////////////////////////////////////////
	// vector types of the protocol
	////////////////////////////////////////

	typedef logic [7:0]  byte_t;         // one lane byte
	typedef logic [31:0] word_t;         // two lanes merged
	typedef logic [5:0]  data_type_t;    // vc bits are not kept
	typedef logic [15:0] word_count_t;   // payload length in bytes
	typedef logic [7:0]  ecc_t;          // bits 7:6 always zero
	typedef logic [15:0] crc_t;

	////////////////////////////////////////
	// framing
	////////////////////////////////////////

	// leader byte sent on every lane before the header
	localparam byte_t sync_byte = 8'hB8;

	localparam data_type_t dt_frame_start = 6'h00;
	localparam data_type_t dt_frame_end   = 6'h01;
	localparam data_type_t dt_long_min    = 6'h10;  // long packets from here up

	////////////////////////////////////////
	// header ecc
	////////////////////////////////////////

	// parity mask per ecc bit over header bits 23:0
	// the column of bit i in these masks is the syndrome of a flip of bit i
	localparam logic [23:0] ecc_mask [6] = '{
		24'hF12CB7,   // ecc[0]
		24'hF2555B,   // ecc[1]
		24'h749A6D,   // ecc[2]
		24'hB8E38E,   // ecc[3]
		24'hDF03F0,   // ecc[4]
		24'hEFFC00    // ecc[5]
	};

	////////////////////////////////////////
	// payload crc
	////////////////////////////////////////

	// x^16 + x^12 + x^5 + 1 in reflected form
	localparam crc_t crc_poly = 16'h8408;
	localparam crc_t crc_seed = 16'hFFFF;

endpackage

// ==== source/rx_pkg.sv ====
package rx_pkg;

	////////////////////////////////////////
	// receiver internals
	////////////////////////////////////////

	// deserialized lane input per clock
	typedef logic [3:0] nibble_t;   // bit 0 arrived first

	typedef enum logic {
		hunt,
		locked
	} align_state_t;

	typedef enum logic [1:0] {
		header,     // waiting for the first word after lock
		wait_hdr,   // decoder busy
		payload,
		crc
	} pkt_state_t;

	// ram write address width unless the top level says otherwise
	localparam int addr_w_default = 16;

endpackage

// ==== source/rx_if.sv ====
`timescale 1ns/100ps

// byte stream of one lane
interface lane_byte_if;
	csi_pkg::byte_t data;
	logic           strobe;   // one cycle per new byte
	logic           locked;   // level while aligned
	logic           rehunt;   // pulse from packet control

	modport aligner (output data, strobe, locked, input rehunt);
	modport merger  (input data, strobe, locked);
	modport control (output rehunt);
endinterface

// merged 32-bit words
interface word_if;
	csi_pkg::word_t word;
	logic           valid;    // one cycle per word
	logic           first;    // first word after both lanes lock

	modport merger   (output word, valid, first);
	modport consumer (input word, valid, first);
	modport monitor  (input word, valid);
endinterface

// header decode request and result
interface hdr_if;
	logic                    take;
	logic                    done;
	csi_pkg::data_type_t     data_type;
	csi_pkg::word_count_t    word_count;
	logic                    corrected;
	logic                    bad;

	modport decoder (input take, output done, data_type, word_count, corrected, bad);
	modport control (output take, input done, data_type, word_count, corrected, bad);
endinterface

// ==== source/lane_aligner.sv ====
`timescale 1ns/100ps

module lane_aligner (
	input  logic            mipi_clk_2,
	input  logic            reset,
	input  rx_pkg::nibble_t nib_i,
	lane_byte_if.aligner    lane
);

	logic [15:0]          shift_q;      // oldest bit in bit 0
	rx_pkg::align_state_t state_q;
	logic [2:0]           offset_q;     // byte boundary inside the window
	logic                 phase_q;      // high on cutting cycles
	logic                 hit;
	logic [2:0]           hit_offset;
	csi_pkg::byte_t       window;

	always_ff @(posedge mipi_clk_2) begin
		shift_q <= {nib_i, shift_q[15:4]};
	end

	// look for the sync byte at all eight offsets, lowest wins
	always_comb begin
		hit = 1'b0;
		hit_offset = '0;
		for (int i = 7; i >= 0; i--) begin
			if (shift_q[i +: 8] == csi_pkg::sync_byte) begin
				hit = 1'b1;
				hit_offset = 3'(i);
			end
		end
	end

	assign window = shift_q[offset_q +: 8];
	assign lane.locked = (state_q == rx_pkg::locked);

	always_ff @(posedge mipi_clk_2) begin
		if (reset || lane.rehunt) begin
			state_q <= rx_pkg::hunt;
			offset_q <= '0;
			phase_q <= 1'b0;
			lane.strobe <= 1'b0;
		end else begin
			lane.strobe <= 1'b0;
			case (state_q)
				rx_pkg::hunt: begin
					if (hit) begin
						state_q <= rx_pkg::locked;
						offset_q <= hit_offset;
						phase_q <= 1'b0;   // sync byte itself is skipped
					end
				end
				rx_pkg::locked: begin
					phase_q <= ~phase_q;
					lane.strobe <= phase_q;
				end
			endcase
		end
	end

	always_ff @(posedge mipi_clk_2) begin
		if (lane.locked && phase_q) begin
			lane.data <= window;
		end
	end

endmodule

// ==== source/lane_merger.sv ====
`timescale 1ns/100ps

module lane_merger (
	input  logic         mipi_clk_2,
	input  logic         reset,
	lane_byte_if.merger  lane0,
	lane_byte_if.merger  lane1,
	word_if.merger       words
);

	logic [1:0]     cnt0, cnt1;      // bytes held per lane
	csi_pkg::byte_t b0, b1, b2, b3;
	logic           both_locked;
	logic           done0, done1;    // lane has both of its bytes
	logic           first_pend;

	assign both_locked = lane0.locked && lane1.locked;
	assign done0 = (cnt0 == 2'd2) || (cnt0 == 2'd1 && lane0.strobe);
	assign done1 = (cnt1 == 2'd2) || (cnt1 == 2'd1 && lane1.strobe);

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !both_locked) begin
			cnt0 <= '0;
			cnt1 <= '0;
			words.valid <= 1'b0;
			words.first <= 1'b0;
			first_pend <= 1'b1;
		end else begin
			words.valid <= done0 && done1;
			words.first <= done0 && done1 && first_pend;
			if (done0 && done1) begin
				cnt0 <= '0;
				cnt1 <= '0;
				first_pend <= 1'b0;
			end else begin
				if (lane0.strobe) cnt0 <= cnt0 + 2'd1;
				if (lane1.strobe) cnt1 <= cnt1 + 2'd1;
			end
		end
	end

	// lane 0 gives bytes 0 and 2, lane 1 gives bytes 1 and 3
	always_ff @(posedge mipi_clk_2) begin
		if (lane0.strobe) begin
			if (cnt0 == 2'd0) b0 <= lane0.data;
			else b2 <= lane0.data;
		end
		if (lane1.strobe) begin
			if (cnt1 == 2'd0) b1 <= lane1.data;
			else b3 <= lane1.data;
		end
		if (done0 && done1) begin
			words.word <= {lane1.strobe ? lane1.data : b3,
				lane0.strobe ? lane0.data : b2, b1, b0};
		end
	end

endmodule

// ==== source/header_decoder.sv ====
`timescale 1ns/100ps

module header_decoder (
	input  logic     mipi_clk_2,
	input  logic     reset,
	word_if.monitor  words,
	hdr_if.decoder   hdr
);

	csi_pkg::ecc_t ecc;
	csi_pkg::ecc_t syndrome;
	logic [23:0]   flip;        // one-hot data bit to correct
	logic [23:0]   fixed;
	logic          ecc_byte_err;
	logic          is_fixed;
	logic          is_bad;

	// syndrome that a flip of data bit i leaves behind
	function automatic csi_pkg::ecc_t bit_syndrome(input int i);
		csi_pkg::ecc_t s;
		s = '0;
		for (int b = 0; b < 6; b++) begin
			s[b] = csi_pkg::ecc_mask[b][i];
		end
		return s;
	endfunction

	////////////////////////////////////////
	// ecc and syndrome
	always_comb begin
		ecc = '0;
		for (int b = 0; b < 6; b++) begin
			ecc[b] = ^(words.word[23:0] & csi_pkg::ecc_mask[b]);
		end
	end

	assign syndrome = ecc ^ words.word[31:24];

	always_comb begin
		for (int i = 0; i < 24; i++) begin
			flip[i] = (syndrome == bit_syndrome(i));
		end
	end

	assign fixed = words.word[23:0] ^ flip;
	// a lone syndrome bit means the ecc byte took the hit
	assign ecc_byte_err = (syndrome != '0) && ((syndrome & (syndrome - 8'd1)) == '0);
	assign is_fixed = (|flip) || ecc_byte_err;
	assign is_bad = (syndrome != '0) && !is_fixed;

	////////////////////////////////////////
	// result register
	always_ff @(posedge mipi_clk_2) begin
		if (reset) hdr.done <= 1'b0;
		else hdr.done <= hdr.take;
	end

	always_ff @(posedge mipi_clk_2) begin
		if (hdr.take) begin
			hdr.data_type <= fixed[5:0];
			hdr.word_count <= fixed[23:8];
			hdr.corrected <= is_fixed;
			hdr.bad <= is_bad;
		end
	end

endmodule

// ==== source/payload_crc.sv ====
`timescale 1ns/100ps

module payload_crc (
	input  logic          mipi_clk_2,
	input  logic          reset,
	word_if.monitor       words,
	input  logic          clear_i,
	input  logic          accumulate_i,
	output csi_pkg::crc_t crc_o
);

	csi_pkg::crc_t crc_next;

	// one byte through the reflected register, lsb first
	function automatic csi_pkg::crc_t fold_byte(input csi_pkg::crc_t c,
		input csi_pkg::byte_t d);
		csi_pkg::crc_t r;
		r = c ^ {8'h00, d};
		for (int k = 0; k < 8; k++) begin
			r = r[0] ? ((r >> 1) ^ csi_pkg::crc_poly) : (r >> 1);
		end
		return r;
	endfunction

	always_comb begin
		crc_next = crc_o;
		for (int n = 0; n < 4; n++) begin
			crc_next = fold_byte(crc_next, words.word[8*n +: 8]);  // byte 0 first
		end
	end

	always_ff @(posedge mipi_clk_2) begin
		if (reset || clear_i) begin
			crc_o <= csi_pkg::crc_seed;
		end else if (accumulate_i && words.valid) begin
			crc_o <= crc_next;
		end
	end

endmodule

// ==== source/packet_fsm.sv ====
`timescale 1ns/100ps

module packet_fsm #(
	parameter int addr_w = rx_pkg::addr_w_default
) (
	input  logic                mipi_clk_2,
	input  logic                reset,
	word_if.consumer            words,
	hdr_if.control              hdr,
	lane_byte_if.control        lane0,
	lane_byte_if.control        lane1,
	input  csi_pkg::crc_t       crc_i,
	output logic                crc_clear_o,
	output logic                crc_accumulate_o,
	output logic                wr_en_o,
	output logic [addr_w-1:0]   wr_addr_o,
	output csi_pkg::word_t      wr_data_o,
	output logic [15:0]         line_o,
	output logic                frame_start_o,
	output logic                frame_end_o,
	output logic                pkt_done_o,
	output logic                crc_ok_o,
	output logic                ecc_err_o,
	output logic                hdr_fixed_o
);

	rx_pkg::pkt_state_t state_q;
	logic [13:0]        words_left;   // payload words still to come
	logic [addr_w-1:0]  addr_q;
	logic               rehunt_q;

	assign hdr.take = (state_q == rx_pkg::header) && words.valid && words.first;
	assign wr_en_o = (state_q == rx_pkg::payload) && words.valid;
	assign wr_addr_o = addr_q;
	assign wr_data_o = words.word;
	assign crc_accumulate_o = wr_en_o;
	assign crc_clear_o = (state_q == rx_pkg::wait_hdr) && hdr.done;
	assign lane0.rehunt = rehunt_q;   // both lanes back to sync hunt
	assign lane1.rehunt = rehunt_q;

	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			state_q <= rx_pkg::header;
			words_left <= '0;
			addr_q <= '0;
			line_o <= '0;
			rehunt_q <= 1'b0;
			frame_start_o <= 1'b0;
			frame_end_o <= 1'b0;
			pkt_done_o <= 1'b0;
			crc_ok_o <= 1'b0;
			ecc_err_o <= 1'b0;
			hdr_fixed_o <= 1'b0;
		end else begin
			rehunt_q <= 1'b0;
			frame_start_o <= 1'b0;
			frame_end_o <= 1'b0;
			pkt_done_o <= 1'b0;
			crc_ok_o <= 1'b0;
			ecc_err_o <= 1'b0;
			hdr_fixed_o <= 1'b0;
			case (state_q)
				rx_pkg::header: begin
					if (hdr.take) state_q <= rx_pkg::wait_hdr;
				end
				rx_pkg::wait_hdr: begin
					if (hdr.done) begin
						hdr_fixed_o <= hdr.corrected && !hdr.bad;
						if (hdr.bad) begin
							ecc_err_o <= 1'b1;
							rehunt_q <= 1'b1;
							state_q <= rx_pkg::header;
						end else if (hdr.data_type >= csi_pkg::dt_long_min) begin
							words_left <= hdr.word_count[15:2];
							state_q <= (hdr.word_count[15:2] == '0) ? rx_pkg::crc : rx_pkg::payload;
						end else begin
							// short packet
							frame_start_o <= (hdr.data_type == csi_pkg::dt_frame_start);
							frame_end_o <= (hdr.data_type == csi_pkg::dt_frame_end);
							if (hdr.data_type == csi_pkg::dt_frame_start) begin
								addr_q <= '0;
								line_o <= '0;
							end
							rehunt_q <= 1'b1;
							state_q <= rx_pkg::header;
						end
					end
				end
				rx_pkg::payload: begin
					if (words.valid) begin
						addr_q <= addr_q + 1'b1;   // wraps at the ram size
						words_left <= words_left - 14'd1;
						if (words_left == 14'd1) state_q <= rx_pkg::crc;
					end
				end
				rx_pkg::crc: begin
					if (words.valid) begin
						pkt_done_o <= 1'b1;
						crc_ok_o <= (crc_i == words.word[15:0]);   // upper half is filler
						line_o <= line_o + 16'd1;
						rehunt_q <= 1'b1;
						state_q <= rx_pkg::header;
					end
				end
			endcase
		end
	end

endmodule

// ==== source/mipi_rx.sv ====
`timescale 1ns/100ps

module mipi_rx #(
	parameter int addr_w = rx_pkg::addr_w_default
) (
	input  logic              mipi_clk_2,
	input  logic              reset,
	input  rx_pkg::nibble_t   lane0_nib_i,
	input  rx_pkg::nibble_t   lane1_nib_i,
	output logic              wr_en_o,
	output logic [addr_w-1:0] wr_addr_o,
	output csi_pkg::word_t    wr_data_o,
	output logic [15:0]       line_o,
	output logic              frame_start_o,
	output logic              frame_end_o,
	output logic              pkt_done_o,
	output logic              crc_ok_o,
	output logic              ecc_err_o,
	output logic              hdr_fixed_o
);

	lane_byte_if lane0_bus ();
	lane_byte_if lane1_bus ();
	word_if      word_bus ();
	hdr_if       hdr_bus ();

	csi_pkg::crc_t crc;
	logic          crc_clear;
	logic          crc_accumulate;

	////////////////////////////////////////
	// lanes to words
	lane_aligner lane_aligner0 (.mipi_clk_2, .reset, .nib_i(lane0_nib_i), .lane(lane0_bus));
	lane_aligner lane_aligner1 (.mipi_clk_2, .reset, .nib_i(lane1_nib_i), .lane(lane1_bus));

	lane_merger lane_merger_inst (.mipi_clk_2, .reset, .lane0(lane0_bus), .lane1(lane1_bus),
		.words(word_bus));

	////////////////////////////////////////
	// packet level
	header_decoder header_decoder_inst (.mipi_clk_2, .reset, .words(word_bus), .hdr(hdr_bus));

	payload_crc payload_crc_inst (.mipi_clk_2, .reset, .words(word_bus), .clear_i(crc_clear),
		.accumulate_i(crc_accumulate), .crc_o(crc));

	packet_fsm #(.addr_w(addr_w)) packet_fsm_inst (
		.mipi_clk_2, .reset,
		.words(word_bus), .hdr(hdr_bus), .lane0(lane0_bus), .lane1(lane1_bus),
		.crc_i(crc), .crc_clear_o(crc_clear), .crc_accumulate_o(crc_accumulate),
		.wr_en_o, .wr_addr_o, .wr_data_o, .line_o,
		.frame_start_o, .frame_end_o, .pkt_done_o, .crc_ok_o, .ecc_err_o, .hdr_fixed_o
	);

endmodule

// ==== test/mipi_rx_props.sv ====
`timescale 1ns/100ps

module mipi_rx_props (
	input logic mipi_clk_2,
	input logic reset,
	input logic wr_en_o,
	input logic frame_start_o,
	input logic frame_end_o,
	input logic pkt_done_o,
	input logic crc_ok_o,
	input logic ecc_err_o,
	input logic hdr_fixed_o
);

	logic any_pulse;

	assign any_pulse = wr_en_o | frame_start_o | frame_end_o | pkt_done_o | crc_ok_o
		| ecc_err_o | hdr_fixed_o;

	// pulse registers are cleared by the first reset edge
	pulses_low_in_reset: assert property (@(posedge mipi_clk_2) reset |=> !any_pulse)
		else $error("pulse output high during reset");

	crc_ok_needs_done: assert property (@(posedge mipi_clk_2) disable iff (reset)
		crc_ok_o |-> pkt_done_o)
		else $error("crc_ok_o high without pkt_done_o");

	no_write_at_frame_start: assert property (@(posedge mipi_clk_2) disable iff (reset)
		!(wr_en_o && frame_start_o))
		else $error("wr_en_o high together with frame_start_o");

endmodule

// ==== test/tb_mipi_rx.sv ====
`timescale 1ns/100ps

module tb_mipi_rx;

	localparam int addr_w = 8;          // narrowest ram address the design takes
	localparam int lead_nibbles = 2;    // idle before each sync byte
	localparam int idle_nibbles = 16;
	localparam int num_packets = 20;
	// longest packet is 72 bytes, 36 per lane at two cycles a byte
	localparam int cycle_limit = num_packets * (72 + lead_nibbles + idle_nibbles + 8) + 100;

	// ecc bits touched by header bit i
	localparam logic [5:0] ecc_col [24] = '{
		6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
		6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
		6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
	};

	logic              mipi_clk_2;
	logic              reset;
	rx_pkg::nibble_t   lane0_nib_i;
	rx_pkg::nibble_t   lane1_nib_i;
	logic              wr_en_o;
	logic [addr_w-1:0] wr_addr_o;
	csi_pkg::word_t    wr_data_o;
	logic [15:0]       line_o;
	logic              frame_start_o, frame_end_o, pkt_done_o;
	logic              crc_ok_o, ecc_err_o, hdr_fixed_o;

	logic [31:0]       lfsr;
	csi_pkg::byte_t    pkt [$];          // packet under construction
	logic [addr_w-1:0] model_addr;
	logic [15:0]       model_line;
	logic [addr_w-1:0] exp_addr_q [$];
	csi_pkg::word_t    exp_data_q [$];
	logic              exp_ok_q [$];
	logic [15:0]       exp_line_q [$];
	int                exp_fs, exp_fe, exp_ecc, exp_fix;
	int                seen_fs, seen_fe, seen_ecc, seen_fix;
	int                errors, err_base, tests_run, tests_failed, cycle_cnt;

	mipi_rx #(.addr_w(addr_w)) mipi_rx_inst (.*);

	bind mipi_rx mipi_rx_props mipi_rx_props_inst (.*);

	initial begin
		mipi_clk_2 = 1'b0;
		forever #2 mipi_clk_2 = ~mipi_clk_2;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < cycle_limit) begin
			@(posedge mipi_clk_2);
			cycle_cnt++;
		end
		$display("timeout: the receiver did not finish within %0d cycles", cycle_limit);
		$display("Simulation finished: FAIL");
		$finish;
	end

	////////////////////////////////////////
	// random source and protocol model
	////////////////////////////////////////

	function automatic logic next_bit();
		logic out;
		out = lfsr[0];
		lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) r = {r[30:0], next_bit()};
		return r;
	endfunction

	function automatic logic [5:0] ecc_of(input logic [23:0] h);
		logic [5:0] e;
		e = '0;
		for (int i = 0; i < 24; i++) begin
			if (h[i]) e = e ^ ecc_col[i];
		end
		return e;
	endfunction

	// serial form, one bit at a time, lsb first
	function automatic csi_pkg::crc_t crc_byte(input csi_pkg::crc_t c, input csi_pkg::byte_t b);
		csi_pkg::crc_t r;
		logic fb;
		r = c;
		for (int k = 0; k < 8; k++) begin
			fb = r[0] ^ b[k];
			r = r >> 1;
			if (fb) r = r ^ csi_pkg::crc_poly;
		end
		return r;
	endfunction

	function automatic bit events_pending();
		return exp_addr_q.size() != 0 || exp_ok_q.size() != 0 || seen_fs < exp_fs
			|| seen_fe < exp_fe || seen_ecc < exp_ecc || seen_fix < exp_fix;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic put_header(input csi_pkg::data_type_t dt, input csi_pkg::word_count_t wc);
		logic [23:0] h;
		h = {wc, 2'b00, dt};   // virtual channel 0
		pkt.delete();
		pkt.push_back(h[7:0]);
		pkt.push_back(h[15:8]);
		pkt.push_back(h[23:16]);
		pkt.push_back({2'b00, ecc_of(h)});
	endtask

	////////////////////////////////////////
	// lane driver
	////////////////////////////////////////

	task automatic send_packet();
		logic            bits0 [$];
		logic            bits1 [$];
		csi_pkg::byte_t  sync;
		int              off0;
		int              off1;
		int              n_nib;
		int              idx;
		rx_pkg::nibble_t nib0;
		rx_pkg::nibble_t nib1;
		sync = csi_pkg::sync_byte;
		off0 = int'(rand_bits(3));
		off1 = int'(rand_bits(3));
		for (int i = 0; i < lead_nibbles * 4 + off0; i++) bits0.push_back(1'b0);
		for (int i = 0; i < lead_nibbles * 4 + off1; i++) bits1.push_back(1'b0);
		for (int k = 0; k < 8; k++) begin
			bits0.push_back(sync[k]);
			bits1.push_back(sync[k]);
		end
		// even bytes on lane 0, odd bytes on lane 1
		for (int i = 0; i < pkt.size(); i++) begin
			for (int k = 0; k < 8; k++) begin
				if (i % 2 == 0) bits0.push_back(pkt[i][k]);
				else bits1.push_back(pkt[i][k]);
			end
		end
		n_nib = (bits0.size() > bits1.size() ? bits0.size() : bits1.size()) / 4 + 1;
		n_nib = n_nib + idle_nibbles;
		for (int n = 0; n < n_nib; n++) begin
			for (int k = 0; k < 4; k++) begin
				idx = 4 * n + k;
				nib0[k] = (idx < bits0.size()) ? bits0[idx] : 1'b0;
				nib1[k] = (idx < bits1.size()) ? bits1[idx] : 1'b0;
			end
			@(posedge mipi_clk_2);
			lane0_nib_i <= nib0;
			lane1_nib_i <= nib1;
		end
	endtask

	task automatic send_short(input csi_pkg::data_type_t dt);
		put_header(dt, 16'(rand_bits(16)));   // frame number
		if (dt == csi_pkg::dt_frame_start) begin
			model_addr = '0;
			model_line = '0;
			exp_fs++;
		end else begin
			exp_fe++;
		end
		send_packet();
	endtask

	// hdr_flips 1 is corrected, 2 is rejected
	task automatic send_long(input int hdr_flips, input bit bad_crc);
		csi_pkg::data_type_t dt;
		csi_pkg::crc_t       crc;
		csi_pkg::byte_t      b;
		int                  wc;
		int                  pos;
		int                  pos2;
		dt = csi_pkg::data_type_t'(rand_bits(6));
		if (dt < csi_pkg::dt_long_min) dt = dt | csi_pkg::dt_long_min;
		wc = (int'(rand_bits(4)) + 1) * 4;
		put_header(dt, 16'(wc));
		crc = csi_pkg::crc_seed;
		for (int i = 0; i < wc; i++) begin
			b = csi_pkg::byte_t'(rand_bits(8));
			pkt.push_back(b);
			crc = crc_byte(crc, b);
		end
		if (bad_crc) begin
			pos = 4 + int'(rand_bits(8)) % wc;
			pkt[pos] = pkt[pos] ^ (8'h01 << rand_bits(3));
		end
		pkt.push_back(crc[7:0]);
		pkt.push_back(crc[15:8]);
		pkt.push_back(8'h00);   // filler
		pkt.push_back(8'h00);
		if (hdr_flips > 0) begin
			pos = int'(rand_bits(8)) % 24;
			pkt[pos / 8] = pkt[pos / 8] ^ (8'h01 << (pos % 8));
		end
		if (hdr_flips > 1) begin
			pos2 = (pos + 1 + int'(rand_bits(8)) % 23) % 24;
			pkt[pos2 / 8] = pkt[pos2 / 8] ^ (8'h01 << (pos2 % 8));
			pkt = pkt[0:3];   // rest of a rejected packet is never looked at
			exp_ecc++;
		end else begin
			if (hdr_flips == 1) exp_fix++;
			for (int j = 0; j < wc / 4; j++) begin
				exp_addr_q.push_back(model_addr);
				exp_data_q.push_back({pkt[4*j+7], pkt[4*j+6], pkt[4*j+5], pkt[4*j+4]});
				model_addr = model_addr + 1'b1;
			end
			model_line = model_line + 16'd1;
			exp_ok_q.push_back(!bad_crc);
			exp_line_q.push_back(model_line);
		end
		send_packet();
	endtask

	task automatic finish_test(input string name);
		while (events_pending()) @(posedge mipi_clk_2);
		compare_value("frame_start_o count", seen_fs, exp_fs);
		compare_value("frame_end_o count", seen_fe, exp_fe);
		compare_value("ecc_err_o count", seen_ecc, exp_ecc);
		compare_value("hdr_fixed_o count", seen_fix, exp_fix);
		tests_run++;
		if (errors == err_base) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - err_base);
		end
		err_base = errors;
	endtask

	////////////////////////////////////////
	// output monitor
	////////////////////////////////////////

	always @(posedge mipi_clk_2) begin
		if (!reset) begin
			if (wr_en_o) begin
				if (exp_addr_q.size() == 0) begin
					$display("write to address %h when no write was expected", wr_addr_o);
					errors++;
				end else begin
					compare_value("wr_addr_o", wr_addr_o, exp_addr_q.pop_front());
					compare_value("wr_data_o", wr_data_o, exp_data_q.pop_front());
				end
			end
			if (pkt_done_o) begin
				if (exp_ok_q.size() == 0) begin
					$display("packet done pulse when no packet was expected");
					errors++;
				end else begin
					compare_value("crc_ok_o", crc_ok_o, exp_ok_q.pop_front());
					compare_value("line_o", line_o, exp_line_q.pop_front());
				end
			end
			if (frame_start_o) begin
				seen_fs++;
				compare_value("line_o", line_o, 0);   // cleared with the pulse
			end
			if (frame_end_o) seen_fe++;
			if (ecc_err_o) seen_ecc++;
			if (hdr_fixed_o) seen_fix++;
		end
	end

	initial begin
		lfsr = 32'h4c873aa1;
		reset = 1'b1;
		lane0_nib_i = '0;
		lane1_nib_i = '0;
		model_addr = '0;
		model_line = '0;
		repeat (5) @(posedge mipi_clk_2);
		reset <= 1'b0;

		send_short(csi_pkg::dt_frame_start);
		repeat (3) send_long(0, 1'b0);
		finish_test("frame start and three lines");

		send_long(0, 1'b0);
		send_long(0, 1'b1);
		finish_test("payload crc good and bad");

		send_long(1, 1'b0);
		finish_test("single bit header error corrected");

		send_long(2, 1'b0);
		send_long(0, 1'b0);
		finish_test("double bit header error and recovery");

		send_short(csi_pkg::dt_frame_end);
		send_short(csi_pkg::dt_frame_start);
		send_long(0, 1'b0);
		finish_test("frame end and new frame");

		repeat (8) send_long(0, rand_bits(1) != 0);
		finish_test("random bit offsets");

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== src.f ====
source/csi_pkg.sv
source/rx_pkg.sv
source/rx_if.sv
source/lane_aligner.sv
source/lane_merger.sv
source/header_decoder.sv
source/payload_crc.sv
source/packet_fsm.sv
source/mipi_rx.sv
test/mipi_rx_props.sv
test/tb_mipi_rx.sv

// ==== Bender.yml ====
package:
  name: mipi_rx

sources:
  - source/csi_pkg.sv
  - source/rx_pkg.sv
  - source/rx_if.sv
  - source/lane_aligner.sv
  - source/lane_merger.sv
  - source/header_decoder.sv
  - source/payload_crc.sv
  - source/packet_fsm.sv
  - source/mipi_rx.sv
  - target: test
    files:
      - test/mipi_rx_props.sv
      - test/tb_mipi_rx.sv
